// File: Makefile
VERILATOR   ?= verilator
TOP         ?= tb_width_down_fifo
FILELIST    ?= build.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --timing --assert
BUILD_FLAGS ?= --binary -j 0
PASS_TEXT   ?= >>> PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# the run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
hw/fifo_pkg.sv
hw/gray_ptr_counter.sv
hw/ptr_sync.sv
hw/dual_clock_ram.sv
hw/fwft_read_ctrl.sv
hw/lane_unpacker.sv
hw/width_down_fifo.sv
tb/tb_clock_gen.sv
tb/tb_width_down_fifo.sv

// File: hw/dual_clock_ram.sv
`timescale 1ns/1ns

module dual_clock_ram import fifo_pkg::*; (
    input  logic              wr_clock,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  fifo_word_u        wr_word,
    input  logic              rd_clock,
    input  logic              rd_en,
    input  logic [ADDR_W-1:0] rd_addr,
    output fifo_word_u        rd_word
);

    fifo_word_u mem [DEPTH];

    // write port
    always_ff @(posedge wr_clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // read port, one cycle latency, output holds between reads
    always_ff @(posedge rd_clock) begin
        if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
    end

endmodule

// File: hw/fifo_pkg.sv
package fifo_pkg;

    // write word and read lane geometry
    localparam int WORD_W     = 32;
    localparam int LANE_W     = 8;
    localparam int LANES      = WORD_W / LANE_W;
    localparam int LANE_IDX_W = 2;

    // memory geometry; pointers carry one extra wrap bit
    localparam int DEPTH      = 16;
    localparam int ADDR_W     = 4;
    localparam int PTR_W      = ADDR_W + 1;

    // one stored word, seen either whole or as byte lanes
    // lane 3 is the most significant byte
    typedef union packed {
        logic [WORD_W-1:0]            raw;
        logic [LANES-1:0][LANE_W-1:0] lane;
    } fifo_word_u;

    // read controller states
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        HOLD
    } rd_state_e;

endpackage

// File: hw/fwft_read_ctrl.sv
`timescale 1ns/1ns

module fwft_read_ctrl import fifo_pkg::*; (
    input  logic                  rd_clock,
    input  logic                  rst_n,
    input  logic                  empty,
    input  logic                  rd_ready,
    input  logic [LANE_IDX_W-1:0] lane_idx,
    output logic                  fetch,
    output logic                  load,
    output logic                  advance,
    output logic                  rd_valid,
    output rd_state_e             state
);

    rd_state_e state_next;
    logic      last_taken;

    assign rd_valid   = (state == HOLD);
    assign advance    = rd_valid && rd_ready;
    assign last_taken = advance && (lane_idx == '0);

    // memory read and pointer step happen on the edge into FETCH
    assign fetch = !empty && ((state == IDLE) || last_taken);

    // memory output is valid during FETCH, latch it for the lanes
    assign load = (state == FETCH);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (fetch) begin
                    state_next = FETCH;
                end
            end
            FETCH: begin
                state_next = HOLD;
            end
            HOLD: begin
                // back to back words when more data is waiting
                if (last_taken) begin
                    state_next = fetch ? FETCH : IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge rd_clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // a lane on offer stays on offer until taken
    assert property (
        @(posedge rd_clock) disable iff (!rst_n)
        (rd_valid && !rd_ready) |=> rd_valid
    ) else $error("rd_valid dropped while stalled");

endmodule

// File: hw/gray_ptr_counter.sv
`timescale 1ns/1ns

module gray_ptr_counter import fifo_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             inc,
    output logic [PTR_W-1:0] ptr_bin,
    output logic [PTR_W-1:0] ptr_gray
);

    logic [PTR_W-1:0] bin_next;
    logic [PTR_W-1:0] gray_next;

    assign bin_next  = ptr_bin + PTR_W'(1);
    assign gray_next = bin_next ^ (bin_next >> 1);

    // gray copy is registered from the next binary value,
    // so the crossing bus is a clean flop output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_bin  <= '0;
            ptr_gray <= '0;
        end else if (inc) begin
            ptr_bin  <= bin_next;
            ptr_gray <= gray_next;
        end
    end

    // each step of the gray pointer flips a single bit
    assert property (
        @(posedge clk) disable iff (!rst_n)
        $countones(ptr_gray ^ $past(ptr_gray)) <= 1
    ) else $error("gray pointer moved by more than one bit");

endmodule

// File: hw/lane_unpacker.sv
`timescale 1ns/1ns

module lane_unpacker import fifo_pkg::*; (
    input  logic                  rd_clock,
    input  logic                  rst_n,
    input  logic                  load,
    input  logic                  advance,
    input  fifo_word_u            word_in,
    output logic [LANE_IDX_W-1:0] lane_idx,
    output logic [LANE_W-1:0]     rd_data
);

    fifo_word_u word_q;

    // held word
    always_ff @(posedge rd_clock) begin
        if (load) begin
            word_q <= word_in;
        end
    end

    // lane index counts down so the top byte goes out first
    always_ff @(posedge rd_clock or negedge rst_n) begin
        if (!rst_n) begin
            lane_idx <= LANE_IDX_W'(LANES - 1);
        end else if (load) begin
            lane_idx <= LANE_IDX_W'(LANES - 1);
        end else if (advance) begin
            lane_idx <= lane_idx - LANE_IDX_W'(1);
        end
    end

    assign rd_data = word_q.lane[lane_idx];

endmodule

// File: hw/ptr_sync.sv
`timescale 1ns/1ns

module ptr_sync import fifo_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [PTR_W-1:0] gray_in,
    output logic [PTR_W-1:0] bin_out
);

    logic [PTR_W-1:0] gray_meta;
    logic [PTR_W-1:0] gray_sync;

    // two flop crossing into the receiving clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gray_meta <= '0;
            gray_sync <= '0;
        end else begin
            gray_meta <= gray_in;
            gray_sync <= gray_meta;
        end
    end

    // gray to binary, each bit is the xor of itself and all above it
    always_comb begin
        for (int i = 0; i < PTR_W; i++) begin
            bin_out[i] = ^(gray_sync >> i);
        end
    end

    // the source moves slower than this clock samples it
    assert property (
        @(posedge clk) disable iff (!rst_n)
        $countones(gray_sync ^ $past(gray_sync)) <= 1
    ) else $error("synchronized pointer jumped by more than one bit");

endmodule

// File: hw/width_down_fifo.sv
`timescale 1ns/1ns

module width_down_fifo import fifo_pkg::*; (
    input  logic              wr_clock,
    input  logic              rd_clock,
    input  logic              rd_rst,
    input  logic              wr_valid,
    output logic              wr_ready,
    input  logic [WORD_W-1:0] wr_data,
    output logic              rd_valid,
    input  logic              rd_ready,
    output logic [LANE_W-1:0] rd_data,
    output logic              overflow,
    output logic [PTR_W-1:0]  rd_word_count
);

    logic                  rd_rst_meta;
    logic                  rd_rst_n;
    logic                  wr_rst_meta;
    logic                  wr_rst_n;
    logic [PTR_W-1:0]      wr_ptr_bin;
    logic [PTR_W-1:0]      wr_ptr_gray;
    logic [PTR_W-1:0]      rd_ptr_bin;
    logic [PTR_W-1:0]      rd_ptr_gray;
    logic [PTR_W-1:0]      wr_ptr_rd;
    logic [PTR_W-1:0]      rd_ptr_wr;
    logic                  full;
    logic                  empty;
    logic                  wr_en;
    logic                  fetch;
    logic                  load;
    logic                  advance;
    logic [LANE_IDX_W-1:0] lane_idx;
    rd_state_e             rd_state;
    fifo_word_u            wr_word;
    fifo_word_u            rd_word;

    // async assert, release through two flops in each domain
    always_ff @(posedge rd_clock or negedge rd_rst) begin
        if (!rd_rst) begin
            rd_rst_meta <= 1'b0;
            rd_rst_n    <= 1'b0;
        end else begin
            rd_rst_meta <= 1'b1;
            rd_rst_n    <= rd_rst_meta;
        end
    end

    always_ff @(posedge wr_clock or negedge rd_rst) begin
        if (!rd_rst) begin
            wr_rst_meta <= 1'b0;
            wr_rst_n    <= 1'b0;
        end else begin
            wr_rst_meta <= 1'b1;
            wr_rst_n    <= wr_rst_meta;
        end
    end

    // write side
    assign full = (wr_ptr_bin[ADDR_W] != rd_ptr_wr[ADDR_W]) &&
                  (wr_ptr_bin[ADDR_W-1:0] == rd_ptr_wr[ADDR_W-1:0]);
    // held low until the write domain leaves reset
    assign wr_ready    = wr_rst_n && !full;
    assign wr_en       = wr_valid && wr_ready;
    assign wr_word.raw = wr_data;

    // one pulse per rejected write
    always_ff @(posedge wr_clock or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            overflow <= 1'b0;
        end else begin
            overflow <= wr_valid && full;
        end
    end

    // read side
    assign empty = (rd_ptr_bin == wr_ptr_rd);

    // stored words only, the word being unpacked is not counted
    always_ff @(posedge rd_clock or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            rd_word_count <= '0;
        end else begin
            rd_word_count <= wr_ptr_rd - rd_ptr_bin;
        end
    end

    gray_ptr_counter i_wr_ptr (
        .clk      (wr_clock),
        .rst_n    (wr_rst_n),
        .inc      (wr_en),
        .ptr_bin  (wr_ptr_bin),
        .ptr_gray (wr_ptr_gray)
    );

    gray_ptr_counter i_rd_ptr (
        .clk      (rd_clock),
        .rst_n    (rd_rst_n),
        .inc      (fetch),
        .ptr_bin  (rd_ptr_bin),
        .ptr_gray (rd_ptr_gray)
    );

    ptr_sync i_wr_ptr_sync (
        .clk     (rd_clock),
        .rst_n   (rd_rst_n),
        .gray_in (wr_ptr_gray),
        .bin_out (wr_ptr_rd)
    );

    ptr_sync i_rd_ptr_sync (
        .clk     (wr_clock),
        .rst_n   (wr_rst_n),
        .gray_in (rd_ptr_gray),
        .bin_out (rd_ptr_wr)
    );

    dual_clock_ram i_ram (
        .wr_clock (wr_clock),
        .wr_en    (wr_en),
        .wr_addr  (wr_ptr_bin[ADDR_W-1:0]),
        .wr_word  (wr_word),
        .rd_clock (rd_clock),
        .rd_en    (fetch),
        .rd_addr  (rd_ptr_bin[ADDR_W-1:0]),
        .rd_word  (rd_word)
    );

    fwft_read_ctrl i_read_ctrl (
        .rd_clock (rd_clock),
        .rst_n    (rd_rst_n),
        .empty    (empty),
        .rd_ready (rd_ready),
        .lane_idx (lane_idx),
        .fetch    (fetch),
        .load     (load),
        .advance  (advance),
        .rd_valid (rd_valid),
        .state    (rd_state)
    );

    lane_unpacker i_unpacker (
        .rd_clock (rd_clock),
        .rst_n    (rd_rst_n),
        .load     (load),
        .advance  (advance),
        .word_in  (rd_word),
        .lane_idx (lane_idx),
        .rd_data  (rd_data)
    );

    // the write pointer stands still while the memory is full
    assert property (
        @(posedge wr_clock) disable iff (!wr_rst_n)
        full |=> $stable(wr_ptr_bin)
    ) else $error("write accepted while full");

    // a word is only fetched when the memory held one
    assert property (
        @(posedge rd_clock) disable iff (!rd_rst_n)
        (rd_state == FETCH) |-> $past(!empty)
    ) else $error("fetch issued from an empty memory");

endmodule

// File: tb/fifo_stim.txt
// first three lines: fill, drain and stream word counts
// then data words: fill words, the rejected overflow word, stream reuses them in order
00000011
00000011
00000018
a1b2c3d4
00000000
ffffffff
12345678
deadbeef
80000001
0f1e2d3c
55aa55aa
c001d00d
7e57da7a
01020304
fedcba98
3c3c0f0f
9abcdef0
b16b00b5
4b1d2e3f
600dcafe
e5e5e5e5

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic rd_clock,
    output logic wr_clock,
    output logic rd_rst
);

    localparam int RD_PERIOD = 8;
    localparam int WR_PERIOD = 12;

    initial begin
        rd_clock = 1'b0;
        forever #(RD_PERIOD / 2) rd_clock = ~rd_clock;
    end

    initial begin
        wr_clock = 1'b0;
        forever #(WR_PERIOD / 2) wr_clock = ~wr_clock;
    end

    // reset held low for four read clock cycles
    initial begin
        rd_rst = 1'b0;
        repeat (4) @(posedge rd_clock);
        #1;
        rd_rst = 1'b1;
    end

endmodule

// File: tb/tb_width_down_fifo.sv
`timescale 1ns/1ns

module tb_width_down_fifo import fifo_pkg::*; ();

    localparam logic [31:0] LFSR_SEED      = 32'hf357_a761;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;
    localparam int          TIMEOUT_MARGIN = 200;

    logic              rd_clock;
    logic              wr_clock;
    logic              rd_rst;
    logic              wr_valid;
    logic              wr_ready;
    logic [WORD_W-1:0] wr_data;
    logic              rd_valid;
    logic              rd_ready;
    logic [LANE_W-1:0] rd_data;
    logic              overflow;
    logic [PTR_W-1:0]  rd_word_count;

    logic [31:0] stim_mem [0:31];
    logic [31:0] sb_words [$];
    logic [31:0] lfsr_state = LFSR_SEED;
    int          fill_count;
    int          drain_count;
    int          stream_count;
    int          data_count;
    int          cycle_limit = 0;
    int          cycle_count;
    int          mismatch_count = 0;
    int          other_count = 0;
    int          waited;

    tb_clock_gen clock_gen (
        .rd_clock (rd_clock),
        .wr_clock (wr_clock),
        .rd_rst   (rd_rst)
    );

    width_down_fifo i_width_down_fifo (
        .wr_clock      (wr_clock),
        .rd_clock      (rd_clock),
        .rd_rst        (rd_rst),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready),
        .wr_data       (wr_data),
        .rd_valid      (rd_valid),
        .rd_ready      (rd_ready),
        .rd_data       (rd_data),
        .overflow      (overflow),
        .rd_word_count (rd_word_count)
    );

    // galois lfsr, one step per bit taken
    function automatic bit next_random_bit();
        bit out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out;
    endfunction

    // data words follow the three phase counts and are reused cyclically
    function automatic logic [31:0] data_word(input int k);
        return stim_mem[3 + (k % data_count)];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            mismatch_count++;
            $display("mismatch %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            other_count++;
            $display("error: %s", what);
        end
    endtask

    task automatic write_words(input int first, input int count, input bit throttle);
        logic [31:0] word;
        @(posedge wr_clock);
        #1;
        for (int i = 0; i < count; i++) begin
            word = data_word(first + i);
            // idle gaps before a word is offered
            while (throttle && next_random_bit()) begin
                wr_valid = 1'b0;
                @(posedge wr_clock);
                #1;
            end
            wr_valid = 1'b1;
            wr_data  = word;
            while (!wr_ready) begin
                @(posedge wr_clock);
                #1;
            end
            // wr_ready is stable here, so the next edge takes the word
            sb_words.push_back(word);
            @(posedge wr_clock);
            #1;
        end
        wr_valid = 1'b0;
    endtask

    task automatic read_lanes(input int count, input bit throttle);
        int          got;
        int          lane_pos;
        bit          ready;
        bit          stalled;
        logic [7:0]  held_data;
        logic [31:0] word;
        got       = 0;
        lane_pos  = 0;
        stalled   = 1'b0;
        held_data = '0;
        while (got < count) begin
            @(posedge rd_clock);
            #1;
            // a stalled lane must still be on offer, unchanged
            if (stalled) begin
                check_true(rd_valid, "rd_valid fell while rd_ready was low");
                check_value("rd_data", 32'(rd_data), 32'(held_data));
            end
            check_true(rd_word_count <= PTR_W'(DEPTH), "rd_word_count above the memory depth");
            ready    = throttle ? next_random_bit() : 1'b1;
            rd_ready = ready;
            if (rd_valid && ready) begin
                if (sb_words.size() == 0) begin
                    check_true(1'b0, "lane arrived with no word outstanding");
                end else begin
                    word = sb_words[0];
                    // most significant byte goes out first
                    check_value("rd_data", 32'(rd_data),
                                32'(word[LANE_W*(LANES-1-lane_pos) +: LANE_W]));
                    lane_pos++;
                    if (lane_pos == LANES) begin
                        void'(sb_words.pop_front());
                        lane_pos = 0;
                    end
                end
                got++;
            end
            stalled   = rd_valid && !ready;
            held_data = rd_data;
        end
        @(posedge rd_clock);
        #1;
        rd_ready = 1'b0;
    endtask

    task automatic check_drained();
        repeat (8) @(posedge rd_clock);
        #1;
        check_value("rd_valid", 32'(rd_valid), 32'h0);
        check_value("rd_word_count", 32'(rd_word_count), 32'h0);
        check_true(sb_words.size() == 0, "accepted words never came out");
    endtask

    initial begin
        wr_valid = 1'b0;
        wr_data  = '0;
        rd_ready = 1'b0;
        $readmemh("tb/fifo_stim.txt", stim_mem);
        fill_count   = int'(stim_mem[0]);
        drain_count  = int'(stim_mem[1]);
        stream_count = int'(stim_mem[2]);
        data_count   = fill_count + 1;
        cycle_limit  = (fill_count + stream_count) * LANES * 8 + TIMEOUT_MARGIN;

        // reset release
        wait (rd_rst === 1'b1);
        check_value("wr_ready", 32'(wr_ready), 32'h0);
        check_value("rd_valid", 32'(rd_valid), 32'h0);
        check_value("overflow", 32'(overflow), 32'h0);
        waited = 0;
        while (!wr_ready && waited < 8) begin
            @(posedge wr_clock);
            #1;
            waited++;
        end
        check_true(wr_ready, "wr_ready stayed low after reset");

        // fill with the read side stalled, one word sits in the holding register
        write_words(0, fill_count, 1'b0);
        repeat (4) @(posedge wr_clock);
        #1;
        check_value("wr_ready", 32'(wr_ready), 32'h0);
        wr_valid = 1'b1;
        wr_data  = data_word(fill_count);
        @(posedge wr_clock);
        #1;
        wr_valid = 1'b0;
        check_value("overflow", 32'(overflow), 32'h1);
        @(posedge wr_clock);
        #1;
        check_value("overflow", 32'(overflow), 32'h0);
        check_value("rd_word_count", 32'(rd_word_count), 32'(DEPTH));

        // drain at full speed
        read_lanes(drain_count * LANES, 1'b0);
        check_drained();

        // both sides throttled
        fork
            write_words(fill_count + 1, stream_count, 1'b1);
            read_lanes(stream_count * LANES, 1'b1);
        join
        check_drained();

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // run limit in rd_clock cycles
    initial begin
        cycle_count = 0;
        while (cycle_limit == 0 || cycle_count < cycle_limit) begin
            @(posedge rd_clock);
            cycle_count++;
        end
        other_count++;
        $display("timeout: the run did not finish within %0d rd_clock cycles", cycle_count);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        $display(">>> FAIL");
        $finish;
    end

endmodule
